// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := milMemChannelTb
FILELIST  := sim.f
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) include/milBridge_params.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the binary exits nonzero when the testbench stops with $$fatal.
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== include/milBridge_params.svh ====
`ifndef MILBRIDGE_PARAMS_SVH
`define MILBRIDGE_PARAMS_SVH

// payload and memory word width.
`define MIL_DATA_W 16

// escape words that open each pair in the memory stream.
`define ESC_SERVICE_ERR 16'hFFA0
`define ESC_SERVICE     16'hFFA1
`define ESC_DATA_ERR    16'hFFA2
`define ESC_DATA        16'hFFA3

`define MEM_FIFO_DEPTH 8
`endif

// ==== rtl/memWordFifo.sv ====
`timescale 1ns/1ps
`include "milBridge_params.svh"

module memWordFifo #(
	parameter int DEPTH = `MEM_FIFO_DEPTH
) (
	input  logic                         clk,
	input  logic                         arstN,

	input  logic                         wrValid,
	input  milBridgePkg::memWord         wrData,
	output logic                         wrReady,

	output logic                         rdValid,
	output milBridgePkg::memWord         rdData,
	input  logic                         rdReady,

	output logic [$clog2(DEPTH + 1)-1:0] level
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	milBridgePkg::memWord mem [DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic             doWrite;
	logic             doRead;

	// pointers wrap explicitly so a depth that is not a power of two works.
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] result;
		if (ptr == PTR_W'(DEPTH - 1))
			result = '0;
		else
			result = ptr + PTR_W'(1);
		return result;
	endfunction

	assign doWrite = wrValid && wrReady;
	assign doRead  = rdValid && rdReady;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];

	//////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doWrite)
				wrPtr <= nextPtr(wrPtr);
			if (doRead)
				rdPtr <= nextPtr(rdPtr);
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else begin
			unique case ({doWrite, doRead})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count; // idle, or read and write together.
			endcase
		end
	end

	assign wrReady = (count != CNT_W'(DEPTH));
	assign rdValid = (count != '0);
	assign level   = count;

endmodule

// ==== rtl/milBridgePkg.sv ====
`include "milBridge_params.svh"

package milBridgePkg;

	typedef logic [`MIL_DATA_W-1:0] milPayload;
	typedef logic [`MIL_DATA_W-1:0] memWord;

	// fill count of the memory word FIFO at its default depth.
	typedef logic [$clog2(`MEM_FIFO_DEPTH + 1)-1:0] fifoCount;

	typedef enum logic [1:0] {
		serviceErr = 2'd0,
		service    = 2'd1,
		dataErr    = 2'd2,
		data       = 2'd3
	} wordKind;

	typedef enum logic [1:0] {idle, sendEscape, sendPayload} packState;

	typedef enum logic [1:0] {waitEscape, waitPayload, present} unpackState;

endpackage

// ==== rtl/milMemChannel.sv ====
`timescale 1ns/1ps

module milMemChannel (
	input  logic                    clk,
	input  logic                    arstN,

	input  logic                    milInValid,
	input  milBridgePkg::wordKind   milInKind,
	input  milBridgePkg::milPayload milInData,
	output logic                    milInReady,

	output logic                    milOutValid,
	output milBridgePkg::wordKind   milOutKind,
	output milBridgePkg::milPayload milOutData,
	input  logic                    milOutReady,

	output milBridgePkg::fifoCount  level
);

	logic                 memValid;
	milBridgePkg::memWord memData;
	logic                 memReady;

	logic                 fifoValid;
	milBridgePkg::memWord fifoData;
	logic                 fifoReady;

	milBridgePkg::fifoCount fifoLevel;

	// each 1553 word becomes an escape word and a payload word.
	milWordPacker packer0 (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (milInValid),
		.inKind   (milInKind),
		.inData   (milInData),
		.inReady  (milInReady),
		.outValid (memValid),
		.outData  (memData),
		.outReady (memReady)
	);

	memWordFifo fifo0 (
		.clk     (clk),
		.arstN   (arstN),
		.wrValid (memValid),
		.wrData  (memData),
		.wrReady (memReady),
		.rdValid (fifoValid),
		.rdData  (fifoData),
		.rdReady (fifoReady),
		.level   (fifoLevel)
	);

	milWordUnpacker unpacker0 (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (fifoValid),
		.inData   (fifoData),
		.inReady  (fifoReady),
		.outValid (milOutValid),
		.outKind  (milOutKind),
		.outData  (milOutData),
		.outReady (milOutReady)
	);

	assign level = fifoLevel;

endmodule

// ==== rtl/milWordPacker.sv ====
`timescale 1ns/1ps
`include "milBridge_params.svh"

module milWordPacker (
	input  logic                   clk,
	input  logic                   arstN,

	input  logic                   inValid,
	input  milBridgePkg::wordKind  inKind,
	input  milBridgePkg::milPayload inData,
	output logic                   inReady,

	output logic                   outValid,
	output milBridgePkg::memWord   outData,
	input  logic                   outReady
);

	milBridgePkg::packState  state;
	milBridgePkg::packState  nextState;
	milBridgePkg::wordKind   kindReg;
	milBridgePkg::milPayload dataReg;
	milBridgePkg::memWord    escWord;

	logic inXfer;
	logic outXfer;

	assign inXfer  = inValid && inReady;
	assign outXfer = outValid && outReady;

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		unique case (state)
			milBridgePkg::idle: begin
				if (inXfer)
					nextState = milBridgePkg::sendEscape;
			end
			milBridgePkg::sendEscape: begin
				if (outXfer)
					nextState = milBridgePkg::sendPayload;
			end
			milBridgePkg::sendPayload: begin
				if (outXfer)
					nextState = milBridgePkg::idle;
			end
			default: nextState = milBridgePkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			state <= milBridgePkg::idle;
		else
			state <= nextState;
	end

	// the word is captured once and held for both halves of the pair.
	always_ff @(posedge clk) begin
		if (inXfer) begin
			kindReg <= inKind;
			dataReg <= inData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output words
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		unique case (kindReg)
			milBridgePkg::serviceErr: escWord = `ESC_SERVICE_ERR;
			milBridgePkg::service:    escWord = `ESC_SERVICE;
			milBridgePkg::dataErr:    escWord = `ESC_DATA_ERR;
			default:                  escWord = `ESC_DATA;
		endcase
	end

	assign inReady  = (state == milBridgePkg::idle);
	assign outValid = (state != milBridgePkg::idle);

	// payload goes out raw, even when it looks like an escape.
	assign outData = (state == milBridgePkg::sendEscape) ? escWord : dataReg;

endmodule

// ==== rtl/milWordUnpacker.sv ====
`timescale 1ns/1ps
`include "milBridge_params.svh"

module milWordUnpacker (
	input  logic                    clk,
	input  logic                    arstN,

	input  logic                    inValid,
	input  milBridgePkg::memWord    inData,
	output logic                    inReady,

	output logic                    outValid,
	output milBridgePkg::wordKind   outKind,
	output milBridgePkg::milPayload outData,
	input  logic                    outReady
);

	milBridgePkg::unpackState state;
	milBridgePkg::unpackState nextState;
	milBridgePkg::wordKind    kindReg;
	milBridgePkg::milPayload  dataReg;

	logic inXfer;
	logic outXfer;

	assign inXfer  = inValid && inReady;
	assign outXfer = outValid && outReady;

	// Maps the first word of a pair to a kind. Anything that is not an
	// escape is taken as a plain data word.
	function automatic milBridgePkg::wordKind decodeKind(input milBridgePkg::memWord word);
		milBridgePkg::wordKind kind;
		unique case (word)
			`ESC_SERVICE_ERR: kind = milBridgePkg::serviceErr;
			`ESC_SERVICE:     kind = milBridgePkg::service;
			`ESC_DATA_ERR:    kind = milBridgePkg::dataErr;
			`ESC_DATA:        kind = milBridgePkg::data;
			default:          kind = milBridgePkg::data;
		endcase
		return kind;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		unique case (state)
			milBridgePkg::waitEscape: begin
				if (inXfer)
					nextState = milBridgePkg::waitPayload;
			end
			milBridgePkg::waitPayload: begin
				if (inXfer)
					nextState = milBridgePkg::present;
			end
			milBridgePkg::present: begin
				if (outXfer)
					nextState = milBridgePkg::waitEscape;
			end
			default: nextState = milBridgePkg::waitEscape;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			state <= milBridgePkg::waitEscape;
		else
			state <= nextState;
	end

	// escape decoding happens only on the first word of a pair.
	always_ff @(posedge clk) begin
		if (inXfer && state == milBridgePkg::waitEscape)
			kindReg <= decodeKind(inData);
		if (inXfer && state == milBridgePkg::waitPayload)
			dataReg <= inData; // second word is always raw payload.
	end

	//////////////////////////////////////////////////////////////////////
	// handshakes
	//////////////////////////////////////////////////////////////////////

	// the memory side stalls while a rebuilt word waits for the consumer.
	assign inReady = (state == milBridgePkg::waitEscape) ||
		(state == milBridgePkg::waitPayload);

	assign outValid = (state == milBridgePkg::present);
	assign outKind  = kindReg;
	assign outData  = dataReg;

endmodule

// ==== sim.f ====
+incdir+include
rtl/milBridgePkg.sv
rtl/milWordPacker.sv
rtl/milWordUnpacker.sv
rtl/memWordFifo.sv
rtl/milMemChannel.sv
verification/milMemChannelTb.sv

// ==== verification/milMemChannelTb.sv ====
`timescale 1ns/1ps
`include "milBridge_params.svh"

module milMemChannelTb;

	localparam int RANDOM_WORDS   = 200;
	localparam int WAIT_LIMIT     = 200;
	localparam int STREAM_LIMIT   = 20000;
	localparam int BLOCKED_CYCLES = 12;
	// escape written, escape read by the unpacker, payload read.
	localparam int NO_STALL_LATENCY = 3;

	logic                    clk;
	logic                    arstN;
	logic                    milInValid;
	milBridgePkg::wordKind   milInKind;
	milBridgePkg::milPayload milInData;
	logic                    milInReady;
	logic                    milOutValid;
	milBridgePkg::wordKind   milOutKind;
	milBridgePkg::milPayload milOutData;
	logic                    milOutReady;
	milBridgePkg::fifoCount  level;

	milBridgePkg::wordKind   kindQ[$];
	milBridgePkg::milPayload dataQ[$];
	int                      acceptQ[$];

	int seed = 32'h7e17046b;
	int cycle = 0;
	bit checkLatency = 0;

	logic                    prevValid = 0;
	logic                    prevReady = 0;
	milBridgePkg::wordKind   prevKind;
	milBridgePkg::milPayload prevData;

	milMemChannel dut0 (
		.clk         (clk),
		.arstN       (arstN),
		.milInValid  (milInValid),
		.milInKind   (milInKind),
		.milInData   (milInData),
		.milInReady  (milInReady),
		.milOutValid (milOutValid),
		.milOutKind  (milOutKind),
		.milOutData  (milOutData),
		.milOutReady (milOutReady),
		.level       (level)
	);

	initial begin
		clk = 0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic failRun(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	outValidHeld: assert property (@(posedge clk) disable iff (!arstN)
		milOutValid && !milOutReady |=> milOutValid)
		else failRun("[FAIL] milOutValid expected 1 got 0");

	levelBound: assert property (@(posedge clk) disable iff (!arstN)
		level <= milBridgePkg::fifoCount'(`MEM_FIFO_DEPTH))
		else failRun($sformatf("[FAIL] level expected at most %h got %h",
			`MEM_FIFO_DEPTH, level));

	// outputs and inputs are settled half a cycle after the edge.
	always @(negedge clk) begin
		if (arstN) begin
			if (milOutValid)
				assert (kindQ.size() != 0)
					else failRun("milOutValid was raised with no word expected.");
			if (prevValid && !prevReady) begin
				assert (milOutKind == prevKind)
					else failRun($sformatf("[FAIL] milOutKind expected %h got %h",
						prevKind, milOutKind));
				assert (milOutData == prevData)
					else failRun($sformatf("[FAIL] milOutData expected %h got %h",
						prevData, milOutData));
			end
			if (checkLatency && milOutValid && !prevValid)
				assert (cycle - acceptQ[0] == NO_STALL_LATENCY)
					else failRun($sformatf("[FAIL] milOutValid latency expected %h got %h",
						NO_STALL_LATENCY, cycle - acceptQ[0]));
			if (milOutValid && milOutReady) begin
				assert (milOutKind == kindQ[0])
					else failRun($sformatf("[FAIL] milOutKind expected %h got %h",
						kindQ[0], milOutKind));
				assert (milOutData == dataQ[0])
					else failRun($sformatf("[FAIL] milOutData expected %h got %h",
						dataQ[0], milOutData));
				void'(kindQ.pop_front());
				void'(dataQ.pop_front());
				void'(acceptQ.pop_front());
			end
			if (milInValid && milInReady) begin // taken on the coming edge.
				kindQ.push_back(milInKind);
				dataQ.push_back(milInData);
				acceptQ.push_back(cycle + 1);
			end
			prevValid = milOutValid;
			prevReady = milOutReady;
			prevKind  = milOutKind;
			prevData  = milOutData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////////////////////////

	// called 1 ns after an edge with milInValid already high.
	task automatic holdUntilTaken();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!milInReady) begin
			if (waited == WAIT_LIMIT)
				failRun("Timed out waiting for milInReady.");
			else begin
				waited++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		#1;
		milInValid = 0;
	endtask

	task automatic sendWord(input milBridgePkg::wordKind kind,
		input milBridgePkg::milPayload payload);
		milInValid = 1;
		milInKind  = kind;
		milInData  = payload;
		holdUntilTaken();
	endtask

	task automatic driveRandomWord();
		int r;
		r = $random(seed);
		milInKind = milBridgePkg::wordKind'(r[1:0]);
		if (r[2])
			milInData = `ESC_SERVICE_ERR + milBridgePkg::milPayload'(r[4:3]); // looks like an escape.
		else
			milInData = milBridgePkg::milPayload'($random(seed));
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (kindQ.size() != 0) begin
			if (waited == WAIT_LIMIT)
				failRun("Timed out waiting for the accepted words to come out.");
			else begin
				waited++;
				@(posedge clk);
			end
		end
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int r;
		int waited;
		int blocked;
		int offered;
		int sent;
		bit taken;

		arstN       = 0;
		milInValid  = 0;
		milInKind   = milBridgePkg::data;
		milInData   = '0;
		milOutReady = 0;
		repeat (5) @(posedge clk);
		#1;
		arstN = 1;

		@(negedge clk);
		assert (milInReady == 1'b1)
			else failRun($sformatf("[FAIL] milInReady expected 1 got %h", milInReady));
		assert (milOutValid == 1'b0)
			else failRun($sformatf("[FAIL] milOutValid expected 0 got %h", milOutValid));
		assert (level == '0)
			else failRun($sformatf("[FAIL] level expected 0 got %h", level));
		@(posedge clk);
		#1;

		// one word of each kind, then payloads that look like escapes.
		milOutReady  = 1;
		checkLatency = 1;
		sendWord(milBridgePkg::serviceErr, 16'h1234);
		sendWord(milBridgePkg::service,    16'h0000);
		sendWord(milBridgePkg::dataErr,    16'hBEEF);
		sendWord(milBridgePkg::data,       16'hFFFF);
		sendWord(milBridgePkg::data,       `ESC_SERVICE);
		sendWord(milBridgePkg::data,       `ESC_DATA);
		sendWord(milBridgePkg::service,    `ESC_SERVICE_ERR);
		waitDrained();
		checkLatency = 0;

		// stall the output until the channel refuses input.
		milOutReady = 0;
		blocked = 0;
		waited  = 0;
		while (blocked < BLOCKED_CYCLES) begin
			if (waited == STREAM_LIMIT)
				failRun("Timed out: milInReady did not stay low with the output stalled.");
			else begin
				@(negedge clk);
				taken   = milInValid && milInReady;
				blocked = milInReady ? 0 : blocked + 1;
				@(posedge clk);
				#1;
				if (taken || !milInValid) begin
					milInValid = 1;
					driveRandomWord();
				end
				waited++;
			end
		end
		assert (level >= milBridgePkg::fifoCount'(`MEM_FIFO_DEPTH - 1))
			else failRun($sformatf("[FAIL] level expected at least %h got %h",
				`MEM_FIFO_DEPTH - 1, level));
		milOutReady = 1;
		holdUntilTaken(); // the word still on offer goes in.
		waitDrained();

		// random stream with random valid and random back-pressure.
		offered = 0;
		sent    = 0;
		waited  = 0;
		while (sent < RANDOM_WORDS) begin
			if (waited == STREAM_LIMIT)
				failRun("Timed out during the random stream.");
			else begin
				@(negedge clk);
				taken = milInValid && milInReady;
				if (taken)
					sent++;
				@(posedge clk);
				#1;
				r = $random(seed);
				if (taken || !milInValid) begin
					if (offered < RANDOM_WORDS && r[0]) begin
						milInValid = 1;
						driveRandomWord();
						offered++;
					end else
						milInValid = 0;
				end
				milOutReady = r[1] | r[2];
				waited++;
			end
		end
		milOutReady = 1;
		waitDrained();
		repeat (4) @(posedge clk);

		if (kindQ.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			failRun("Words were accepted but never came out.");
		end
	end

endmodule
